/* src/obj_settings.svh */
/*
 * object renderer geometry and memory layout.
 * table size, word addresses of the object table and tile data,
 * and the pixel values the renderer treats specially.
 */
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// object table, 4 words per entry: x, y, code, attribute.
`define OBJ_MAX         16
`define OBJ_TABLE_BASE  24'h00_0000

// tile data. 16 rows of 4 words, 4 pixels per word.
`define OBJ_TILE_BASE   24'h01_0000
`define OBJ_TILE_WORDS  64

// attribute high byte that closes the table.
`define OBJ_END_MARK    8'hFF

// colour index never written to the line buffer.
`define OBJ_TRANSPARENT 15

`endif

/* src/obj_bus_pkg.sv */
/*
 * memory bus types.
 * word address and data of the shared memory port, and the ids
 * of the two masters competing for it.
 */
package obj_bus_pkg;

    localparam int MEM_AW = 24;
    localparam int MEM_DW = 16;

    typedef logic [MEM_AW-1:0] mem_addr_t;   // word address.
    typedef logic [MEM_DW-1:0] mem_data_t;

    // also used as the grant vector index.
    typedef enum logic {
        REQ_SCAN,
        REQ_FETCH
    } req_id_e;

endpackage

/* src/obj_types_pkg.sv */
/*
 * object types.
 * table entry layout, the attribute word with its two decodings,
 * and the tile job handed from the table scanner to the fetcher.
 */
package obj_types_pkg;

    // attribute word, decoded fields.
    typedef struct packed {
        logic [3:0] tile_n;   // extra tile columns.
        logic [3:0] tile_m;   // extra tile rows.
        logic       vflip;
        logic       hflip;
        logic       spare;
        logic [4:0] pal;
    } obj_attr_s;

    // attribute word, raw bytes for the end of table test.
    typedef struct packed {
        logic [7:0] mark;
        logic [7:0] low;
    } obj_attr_raw_s;

    typedef union packed {
        obj_attr_s     f;
        obj_attr_raw_s raw;
    } obj_attr_u;

    // one table entry as read from memory.
    typedef struct packed {
        logic [15:0] x;       // only 9 bits take part.
        logic [15:0] y;       // 10 bits stored, 9 compared.
        logic [15:0] code;
        obj_attr_u   attr;
    } obj_entry_s;

    // one tile row to draw.
    typedef struct packed {
        logic [15:0] code;    // tile code with row and column added.
        logic [3:0]  vsub;    // pixel row inside the tile.
        logic [8:0]  xpos;
        logic        hflip;
        logic [4:0]  pal;
    } tile_job_s;

endpackage

/* src/obj_bus_if.sv */
/*
 * memory request/response channel.
 * one request at a time per master, the response marks its end.
 */
`timescale 1ns/10ps

interface obj_bus_if
    import obj_bus_pkg::*;
();
    logic      req_valid;
    logic      req_ready;
    mem_addr_t addr;        // held while req_valid waits.
    logic      rsp_valid;   // one cycle, ends the transaction.
    mem_data_t rdata;

    modport master (
        output req_valid,
        output addr,
        input  req_ready,
        input  rsp_valid,
        input  rdata
    );

    modport slave (
        input  req_valid,
        input  addr,
        output req_ready,
        output rsp_valid,
        output rdata
    );

endinterface

/* src/obj_tile_match.sv */
/*
 * tile row match for one object.
 * finds which tile row of a multi-tile object crosses the line,
 * the pixel row inside it and the tile code for column n.
 * outputs are registered, one cycle after the inputs.
 */
`timescale 1ns/10ps

module obj_tile_match
    import obj_bus_pkg::*;
(
    input  logic       clk,
    input  mem_data_t  obj_code,
    input  logic [3:0] tile_n,
    input  logic [3:0] tile_m,
    input  logic [3:0] n,
    input  logic       vflip,
    input  logic [8:0] vrender,
    input  logic [9:0] obj_y,
    output logic [3:0] vsub,
    output logic       inzone,
    output mem_data_t  code_mn
);
    logic [8:0]  dy;      // line relative to object top, wraps at 512.
    logic [15:0] match;   // one bit per tile row.
    logic [3:0]  m;
    logic [3:0]  row;
    logic [3:0]  col;

    assign dy = vrender - obj_y[8:0];

    // row g covers lines 16g to 16g+15 of the object.
    for (genvar g = 0; g < 16; g++) begin : g_row
        assign match[g] = (dy[8:4] == 5'(g)) && (4'(g) <= tile_m);
    end

    // at most one bit set, so or-ing indices gives m.
    always_comb begin
        m = '0;
        for (int i = 0; i < 16; i++) begin
            if (match[i]) begin
                m = m | 4'(i);
            end
        end
    end

    assign row = vflip ? tile_m - m : m;   // flipped block reads rows bottom up.
    assign col = (tile_n != 4'd0) ? n : 4'd0;   // single column ignores n.

    always_ff @(posedge clk) begin
        inzone  <= |match;
        vsub    <= dy[3:0] ^ {4{vflip}};   // flip inside the tile too.
        code_mn <= obj_code + {8'd0, row, col};   // carries into upper bits.
    end

endmodule

/* src/obj_table_scan.sv */
/*
 * object table scanner.
 * reads the table entry by entry, checks each object against the
 * line and hands out one tile job per visible tile column.
 */
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_table_scan
    import obj_bus_pkg::*;
    import obj_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [8:0] vrender,
    output logic       busy,
    output logic       scan_done,
    obj_bus_if.master  bus,
    output logic       job_valid,
    output tile_job_s  job,
    input  logic       job_ready
);
    localparam int IDX_W = $clog2(`OBJ_MAX);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,     // entry word request.
        S_WAIT,    // entry word response.
        S_MATCH,   // match block samples entry and column.
        S_CHECK,   // match result ready.
        S_JOB,     // job offered to the fetcher.
        S_NEXT
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] idx;     // table entry.
    logic [1:0]       word;    // word inside the entry.
    logic [3:0]       n;       // tile column.
    logic [8:0]       vline;
    obj_entry_s       entry;
    obj_attr_u        rsp_attr;
    logic [3:0]       vsub;
    logic             inzone;
    mem_data_t        code_mn;
    logic             last_col;
    logic             last_obj;

    assign rsp_attr  = bus.rdata;
    assign last_col  = n == entry.attr.f.tile_n;
    assign last_obj  = idx == IDX_W'(`OBJ_MAX - 1);
    assign busy      = state != S_IDLE;
    assign job_valid = state == S_JOB;

    assign bus.req_valid = state == S_REQ;
    assign bus.addr      = `OBJ_TABLE_BASE + mem_addr_t'({idx, word});

    obj_tile_match u_match (
        .clk      (clk),
        .obj_code (entry.code),
        .tile_n   (entry.attr.f.tile_n),
        .tile_m   (entry.attr.f.tile_m),
        .n        (n),
        .vflip    (entry.attr.f.vflip),
        .vrender  (vline),
        .obj_y    (entry.y[9:0]),
        .vsub     (vsub),
        .inzone   (inzone),
        .code_mn  (code_mn)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            scan_done <= 1'b0;
            idx       <= '0;
            word      <= '0;
            n         <= '0;
        end else begin
            scan_done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    idx   <= '0;
                    word  <= '0;
                    state <= S_REQ;
                end
                S_REQ: if (bus.req_ready) state <= S_WAIT;
                S_WAIT: if (bus.rsp_valid) begin
                    word <= word + 2'd1;   // wraps to 0 after the attribute.
                    if (word != 2'd3) begin
                        state <= S_REQ;
                    end else if (rsp_attr.raw.mark == `OBJ_END_MARK) begin
                        state     <= S_IDLE;   // end of table.
                        scan_done <= 1'b1;
                    end else begin
                        n     <= '0;
                        state <= S_MATCH;
                    end
                end
                S_MATCH: state <= S_CHECK;
                S_CHECK: state <= inzone ? S_JOB : S_NEXT;   // row test same for all n.
                S_JOB: if (job_ready) begin
                    if (last_col) begin
                        state <= S_NEXT;
                    end else begin
                        n     <= n + 4'd1;
                        state <= S_MATCH;
                    end
                end
                S_NEXT: if (last_obj) begin
                    state     <= S_IDLE;
                    scan_done <= 1'b1;
                end else begin
                    idx   <= idx + 1'b1;
                    state <= S_REQ;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // entry words, line number and job payload.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) vline <= vrender;
        if (state == S_WAIT && bus.rsp_valid) begin
            case (word)
                2'd0:    entry.x    <= bus.rdata;
                2'd1:    entry.y    <= bus.rdata;
                2'd2:    entry.code <= bus.rdata;
                default: entry.attr <= rsp_attr;
            endcase
        end
        if (state == S_CHECK) begin
            job.code  <= code_mn;
            job.vsub  <= vsub;
            job.xpos  <= entry.x[8:0] + {n, 4'd0};   // wraps at 512.
            job.hflip <= entry.attr.f.hflip;
            job.pal   <= entry.attr.f.pal;
        end
    end

endmodule

/* src/obj_tile_fetch.sv */
/*
 * tile row fetcher.
 * reads the 4 words of one tile row and writes the opaque pixels
 * to the line buffer, one per cycle, while the next word is fetched.
 */
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_tile_fetch
    import obj_bus_pkg::*;
    import obj_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       job_valid,
    input  tile_job_s  job,
    output logic       job_ready,
    obj_bus_if.master  bus,
    output logic       buf_we,
    output logic [8:0] buf_x,
    output logic [8:0] buf_pix
);
    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT,
        F_DRAIN   // last word being written out.
    } state_e;

    state_e     state;
    tile_job_s  job_q;
    logic [1:0] word;      // words received so far.
    logic [1:0] widx;      // word index in memory.
    logic [2:0] pix_cnt;   // pixels left in sreg.
    logic [3:0] pos;       // x offset inside the tile.
    mem_data_t  sreg;
    logic [3:0] pix;

    assign job_ready = state == F_IDLE;

    // hflip walks the words backwards and each word low nibble first.
    assign widx = job_q.hflip ? ~word : word;

    // a response must not land before sreg is nearly drained.
    assign bus.req_valid = (state == F_REQ) && (pix_cnt <= 3'd2);
    assign bus.addr = `OBJ_TILE_BASE
                    + mem_addr_t'(job_q.code) * mem_addr_t'(`OBJ_TILE_WORDS)
                    + mem_addr_t'({job_q.vsub, widx});

    assign pix     = job_q.hflip ? sreg[3:0] : sreg[15:12];
    assign buf_we  = (pix_cnt != 3'd0) && (pix != 4'(`OBJ_TRANSPARENT));
    assign buf_x   = job_q.xpos + 9'(pos);   // wraps at 512.
    assign buf_pix = {job_q.pal, pix};

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= F_IDLE;
            word    <= '0;
            pix_cnt <= '0;
            pos     <= '0;
        end else begin
            if (pix_cnt != 3'd0) begin
                pix_cnt <= pix_cnt - 3'd1;
                pos     <= pos + 4'd1;
            end
            case (state)
                F_IDLE: if (job_valid) begin
                    word  <= '0;
                    pos   <= '0;
                    state <= F_REQ;
                end
                F_REQ: if (bus.req_valid && bus.req_ready) state <= F_WAIT;
                F_WAIT: if (bus.rsp_valid) begin
                    pix_cnt <= 3'd4;   // previous word is done by now.
                    word    <= word + 2'd1;
                    state   <= (word == 2'd3) ? F_DRAIN : F_REQ;
                end
                F_DRAIN: if (pix_cnt == 3'd1) state <= F_IDLE;
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && job_valid) job_q <= job;
        if (state == F_WAIT && bus.rsp_valid) begin
            sreg <= bus.rdata;
        end else if (pix_cnt != 3'd0) begin
            sreg <= job_q.hflip ? sreg >> 4 : sreg << 4;   // next nibble.
        end
    end

endmodule

/* src/obj_mem_arbiter.sv */
/*
 * memory port arbiter.
 * round-robin between the table scanner and the tile fetcher.
 * a grant lasts until the response, so memory sees one request.
 */
`timescale 1ns/10ps

module obj_mem_arbiter
    import obj_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    obj_bus_if.slave  scan_bus,
    obj_bus_if.slave  fetch_bus,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_addr_t mem_addr,
    input  logic      mem_rsp_valid,
    input  mem_data_t mem_rdata
);
    logic [1:0] req;        // indexed by req_id_e.
    logic [1:0] grant;      // one-hot while owned.
    logic       accepted;   // request taken, waiting for data.
    req_id_e    last;       // previous winner.
    req_id_e    pick;

    assign req[REQ_SCAN]  = scan_bus.req_valid;
    assign req[REQ_FETCH] = fetch_bus.req_valid;

    // on a tie the one that lost last time wins.
    always_comb begin
        if (req == 2'b11) begin
            pick = (last == REQ_SCAN) ? REQ_FETCH : REQ_SCAN;
        end else if (req[REQ_FETCH]) begin
            pick = REQ_FETCH;
        end else begin
            pick = REQ_SCAN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant    <= '0;
            accepted <= 1'b0;
            last     <= REQ_FETCH;   // scanner goes first.
        end else if (grant == 2'b00) begin
            if (|req) begin
                grant <= 2'b01 << pick;
                last  <= pick;
            end
        end else if (!accepted) begin
            if (mem_req_valid && mem_req_ready) accepted <= 1'b1;
        end else if (mem_rsp_valid) begin
            grant    <= '0;
            accepted <= 1'b0;
        end
    end

    assign mem_req_valid = !accepted && |(grant & req);
    assign mem_addr      = grant[REQ_FETCH] ? fetch_bus.addr : scan_bus.addr;

    assign scan_bus.req_ready  = grant[REQ_SCAN] && !accepted && mem_req_ready;
    assign fetch_bus.req_ready = grant[REQ_FETCH] && !accepted && mem_req_ready;

    // response goes to the owner only.
    assign scan_bus.rsp_valid  = grant[REQ_SCAN] && accepted && mem_rsp_valid;
    assign fetch_bus.rsp_valid = grant[REQ_FETCH] && accepted && mem_rsp_valid;
    assign scan_bus.rdata      = mem_rdata;
    assign fetch_bus.rdata     = mem_rdata;

endmodule

/* src/obj_line_render.sv */
/*
 * object line renderer, top level.
 * renders the objects crossing line vrender into the line buffer
 * write port, reading table and tiles from one shared memory port.
 */
`timescale 1ns/10ps

module obj_line_render
    import obj_bus_pkg::*;
    import obj_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [8:0] vrender,
    output logic       mem_req_valid,
    input  logic       mem_req_ready,
    output mem_addr_t  mem_addr,
    input  logic       mem_rsp_valid,
    input  mem_data_t  mem_rdata,
    output logic       buf_we,
    output logic [8:0] buf_x,
    output logic [8:0] buf_pix,
    output logic       busy,
    output logic       done
);
    obj_bus_if scan_bus ();
    obj_bus_if fetch_bus ();

    tile_job_s job;
    logic      job_valid;
    logic      job_ready;   // also the fetcher idle flag.
    logic      scan_busy;
    logic      scan_done;
    logic      done_pend;   // table done, last tile still drawing.

    assign busy = scan_busy | scan_done | done_pend;

    obj_table_scan u_scan (
        .clk       (clk),
        .reset     (reset),
        .start     (start & ~busy),   // no restart mid line.
        .vrender   (vrender),
        .busy      (scan_busy),
        .scan_done (scan_done),
        .bus       (scan_bus.master),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready)
    );

    obj_tile_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .bus       (fetch_bus.master),
        .buf_we    (buf_we),
        .buf_x     (buf_x),
        .buf_pix   (buf_pix)
    );

    obj_mem_arbiter u_arb (
        .clk           (clk),
        .reset         (reset),
        .scan_bus      (scan_bus.slave),
        .fetch_bus     (fetch_bus.slave),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_addr      (mem_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata)
    );

    // done waits for the fetcher to go idle.
    always_ff @(posedge clk) begin
        if (reset) begin
            done_pend <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (scan_done) begin
                done_pend <= 1'b1;
            end else if (done_pend && job_ready) begin
                done_pend <= 1'b0;
                done      <= 1'b1;   // one cycle pulse.
            end
        end
    end

endmodule

/* verification/obj_line_render_props.sv */
/*
 * protocol checks for the object line renderer.
 * one owner per memory transaction, address held while a request
 * waits, one transaction in flight, quiet outputs in reset.
 */
`timescale 1ns/10ps

module obj_line_render_props
    import obj_bus_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic [1:0] grant,
    input logic       mem_req_valid,
    input logic       mem_req_ready,
    input mem_addr_t  mem_addr,
    input logic       mem_rsp_valid,
    input logic       done,
    input logic       buf_we,
    input logic       busy
);
    int   prop_errs = 0;   // failed assertions so far.
    logic outstanding;     // request taken and response not seen yet.

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            outstanding <= 1'b1;
        end else if (mem_rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // the owner keeps its grant until the response.
    one_grant: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> $onehot(grant))
        else begin
            prop_errs++;
            $error("no single grant held while a memory request is in flight");
        end

    // a waiting request keeps its address.
    addr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr))
        else begin
            prop_errs++;
            $error("request dropped or address changed while waiting");
        end

    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !mem_req_valid)
        else begin
            prop_errs++;
            $error("new memory request before the response");
        end

    // outputs clear the cycle after a reset edge.
    reset_quiet: assert property (@(posedge clk)
        reset |=> !done && !buf_we && !mem_req_valid && !busy)
        else begin
            prop_errs++;
            $error("outputs active during reset");
        end

endmodule

bind obj_line_render obj_line_render_props u_props (
    .clk           (clk),
    .reset         (reset),
    .grant         (u_arb.grant),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_addr      (mem_addr),
    .mem_rsp_valid (mem_rsp_valid),
    .done          (done),
    .buf_we        (buf_we),
    .busy          (busy)
);

/* verification/obj_line_render_tb.sv */
/*
 * testbench for the object line renderer.
 * memory model with random latency and ready stalls, line buffer
 * capture, and a reference model of each line from the same memory.
 */
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_line_render_tb
    import obj_bus_pkg::*;
();
    localparam int CLK_PERIOD   = 100;
    localparam int N_DIRECTED   = 6;
    localparam int N_RANDOM     = 24;
    localparam int MAX_LAT      = 4;
    localparam int STALL_MARGIN = 8;
    localparam longint TIMEOUT_CYCLES = longint'(N_DIRECTED + N_RANDOM) * `OBJ_MAX * 16 * 4
                                      * (MAX_LAT + STALL_MARGIN) + 100;
    localparam logic [9:0] EMPTY = 10'h200;   // bit 9 marks a pixel never written.

    logic       clk;
    logic       reset = 1'b1;
    logic       start = 1'b0;
    logic [8:0] vrender = '0;
    logic       mem_req_valid;
    logic       mem_req_ready = 1'b0;
    mem_addr_t  mem_addr;
    logic       mem_rsp_valid = 1'b0;
    mem_data_t  mem_rdata = '0;
    logic       buf_we;
    logic [8:0] buf_x;
    logic [8:0] buf_pix;
    logic       busy;
    logic       done;

    mem_data_t  mem [mem_addr_t];   // unwritten words read the fill pattern.
    logic [9:0] line_buf [512];
    logic [9:0] exp_buf [512];
    logic       clear_req = 1'b0;
    logic       pending = 1'b0;     // memory busy with one request.
    mem_addr_t  pend_addr;
    int         lat_cnt;
    int         err_cnt = 0;
    int         check_cnt = 0;
    string      test_name = "none";

    obj_line_render UUT (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .vrender       (vrender),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_addr      (mem_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .buf_we        (buf_we),
        .buf_x         (buf_x),
        .buf_pix       (buf_pix),
        .busy          (busy),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic mem_data_t mem_fill(input mem_addr_t a);
        logic [31:0] h;
        h = {8'd0, a} * 32'h9E37_79B1;   // every address bit reaches the result.
        return h[27:12];
    endfunction

    function automatic mem_data_t mem_read(input mem_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return mem_fill(a);
    endfunction

    function automatic void set_entry(input int e, input mem_data_t x, input mem_data_t y,
                                      input mem_data_t code, input mem_data_t attr);
        mem[mem_addr_t'(`OBJ_TABLE_BASE + 4 * e)]     = x;
        mem[mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 1)] = y;
        mem[mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 2)] = code;
        mem[mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 3)] = attr;
    endfunction

    // every entry carries the end mark.
    function automatic void clear_table();
        for (int e = 0; e < `OBJ_MAX; e++) begin
            set_entry(e, '0, '0, '0, {`OBJ_END_MARK, 8'h00});
        end
    endfunction

    function automatic void set_tile_row(input mem_data_t code, input logic [3:0] row,
                                         input logic [63:0] words);
        for (int i = 0; i < 4; i++) begin
            mem[mem_addr_t'(`OBJ_TILE_BASE + code * `OBJ_TILE_WORDS + 4 * row + i)] =
                words[63 - 16 * i -: 16];
        end
    endfunction

    // cnt entries, then the end mark unless the table is full.
    function automatic void random_table(input logic [8:0] line, input int cnt);
        mem_data_t y;
        clear_table();
        for (int e = 0; e < cnt; e++) begin
            y = ($urandom_range(1, 0) != 0) ? 16'(line - $urandom_range(63, 0))
                                             : 16'($urandom);
            set_entry(e, 16'($urandom), y, 16'($urandom),
                      {4'($urandom_range(3, 0)), 4'($urandom_range(3, 0)), 8'($urandom)});
        end
    endfunction

    // expected line buffer in table order. later pixels overwrite earlier ones.
    function automatic void ref_line(input logic [8:0] line);
        mem_data_t  x;
        mem_data_t  y;
        mem_data_t  code;
        mem_data_t  attr;
        mem_data_t  tcode;
        mem_data_t  w;
        logic [8:0] dy;
        logic [8:0] xp;
        logic [3:0] row;
        logic [3:0] vs;
        logic [3:0] c;
        int         src;
        logic       stop;
        for (int i = 0; i < 512; i++) begin
            exp_buf[i] = EMPTY;
        end
        stop = 1'b0;
        for (int e = 0; e < `OBJ_MAX && !stop; e++) begin
            x    = mem_read(mem_addr_t'(`OBJ_TABLE_BASE + 4 * e));
            y    = mem_read(mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 1));
            code = mem_read(mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 2));
            attr = mem_read(mem_addr_t'(`OBJ_TABLE_BASE + 4 * e + 3));
            dy   = line - y[8:0];   // 9-bit wrap.
            if (attr[15:8] == `OBJ_END_MARK) begin
                stop = 1'b1;
            end else if (dy[8:4] <= {1'b0, attr[11:8]}) begin
                row = attr[7] ? attr[11:8] - dy[7:4] : dy[7:4];   // vflip reads rows bottom up.
                vs  = attr[7] ? ~dy[3:0] : dy[3:0];
                for (int n = 0; n <= int'(attr[15:12]); n++) begin
                    tcode = code + {8'd0, row, 4'(n)};
                    xp    = x[8:0] + 9'(16 * n);
                    for (int p = 0; p < 16; p++) begin
                        src = attr[6] ? 15 - p : p;   // hflip mirrors inside the tile.
                        w = mem_read(mem_addr_t'(`OBJ_TILE_BASE + tcode * `OBJ_TILE_WORDS
                                                 + 4 * vs + src / 4));
                        c = 4'(w >> (4 * (3 - src % 4)));
                        if (c != 4'(`OBJ_TRANSPARENT)) begin
                            exp_buf[9'(xp + p)] = {1'b0, attr[4:0], c};
                        end
                    end
                end
            end
        end
    endfunction

    // memory model with 1 to 4 cycles per read. ready drops a quarter of the time.
    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            pending       <= 1'b0;
        end else begin
            mem_req_ready <= ($urandom_range(3, 0) != 0);
            mem_rsp_valid <= 1'b0;
            if (pending) begin
                if (lat_cnt <= 1) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rdata     <= mem_read(pend_addr);
                    pending       <= 1'b0;
                end else begin
                    lat_cnt <= lat_cnt - 1;
                end
            end else if (mem_req_valid && mem_req_ready) begin
                pending   <= 1'b1;
                pend_addr <= mem_addr;
                lat_cnt   <= $urandom_range(MAX_LAT, 1);
            end
        end
    end

    // line buffer.
    always @(posedge clk) begin
        if (clear_req) begin
            for (int i = 0; i < 512; i++) begin
                line_buf[i] <= EMPTY;
            end
        end else if (buf_we) begin
            line_buf[buf_x] <= {1'b0, buf_pix};
        end
    end

    // compare the whole line once done pulses.
    always @(posedge clk) begin
        if (done) begin
            assert (!busy) else begin
                err_cnt++;
                $display("%s: busy is still high while done pulses", test_name);
            end
            for (int i = 0; i < 512; i++) begin
                check_cnt++;
                assert (line_buf[i] === exp_buf[i]) else begin
                    err_cnt++;
                    $display("Error %s: x %0d expected %h actual %h",
                             test_name, i, exp_buf[i], line_buf[i]);
                end
            end
        end
    end

    task automatic run_line(input string name, input logic [8:0] line);
        test_name = name;
        ref_line(line);
        @(posedge clk);
        start     <= 1'b1;
        vrender   <= line;
        clear_req <= 1'b1;
        @(posedge clk);
        start     <= 1'b0;
        clear_req <= 1'b0;
        do begin
            @(posedge clk);
            assert (busy || done) else begin   // busy spans start to done.
                err_cnt++;
                $display("%s: busy dropped before done", test_name);
            end
        end while (!done);
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout in %s, done never came", test_name);
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [8:0] line;
        void'($urandom(98));
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // one tile with transparent nibbles in a known row. second object a row too low.
        clear_table();
        set_entry(0, 16'd20, 16'd100, 16'd5, {4'd0, 4'd0, 3'b000, 5'd3});
        set_entry(1, 16'd300, 16'd90, 16'd5, 16'h0009);
        set_tile_row(16'd5, 4'd7, 64'h012F_F3F4_5678_9ABF);
        run_line("single_tile", 9'd107);

        // 4x3 block on its middle row with a code carry past bit 7.
        clear_table();
        set_entry(0, 16'd100, 16'd50, 16'h00F8, {4'd3, 4'd2, 8'h05});
        run_line("multi_tile", 9'd75);

        clear_table();
        set_entry(0, 16'd40, 16'd200, 16'h0020, {4'd1, 4'd3, 3'b100, 5'd7});
        set_entry(1, 16'd200, 16'd210, 16'h0040, {4'd2, 4'd0, 3'b010, 5'd9});
        set_entry(2, 16'd330, 16'd205, 16'h0060, {4'd1, 4'd1, 3'b110, 5'd2});
        run_line("flips", 9'd219);

        // block wrapping in y and x. y bit 9 ignored and the entry past the mark unused.
        clear_table();
        set_entry(0, 16'd500, 16'd500, 16'h0100, {4'd1, 4'd2, 8'h04});
        set_entry(1, 16'd60, 16'h0205, 16'h0011, 16'h000C);
        set_entry(2, 16'd150, 16'd400, 16'h0012, 16'h0001);
        set_entry(4, 16'd80, 16'd8, 16'h0013, 16'h0002);
        run_line("table_limits", 9'd10);
        run_line("table_wrap", 9'd511);

        line = 9'($urandom);
        random_table(line, `OBJ_MAX);
        run_line("table_full", line);

        for (int k = 0; k < N_RANDOM; k++) begin
            line = 9'($urandom);
            random_table(line, $urandom_range(`OBJ_MAX, 0));
            run_line($sformatf("random_%0d", k), line);
        end

        $display("checks %0d, errors %0d, assertion errors %0d",
                 check_cnt, err_cnt, UUT.u_props.prop_errs);
        if (err_cnt == 0 && UUT.u_props.prop_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/obj_bus_pkg.sv
src/obj_types_pkg.sv
src/obj_bus_if.sv
src/obj_tile_match.sv
src/obj_table_scan.sv
src/obj_tile_fetch.sv
src/obj_mem_arbiter.sv
src/obj_line_render.sv
verification/obj_line_render_props.sv
verification/obj_line_render_tb.sv
